/* hw/viz_settings.svh */
`ifndef VIZ_SETTINGS_SVH
`define VIZ_SETTINGS_SVH

// bar grid geometry
`define NUM_BANDS    6
`define NUM_BLOCKS   6
`define BAR_X0       10
`define BAR_Y0       10
`define BAR_PITCH_X  105
`define BAR_PITCH_Y  79
`define BLOCK_W      95
`define BLOCK_H      69
// level needed per lit block
`define BAR_STEP     300

// sprite geometry and motion
`define SPRITE_SIZE  32
`define SPRITE_X0    240
`define SPRITE_Y0    80
`define SPRITE_STEP  16
`define SPRITE_XMIN  0
`define SPRITE_XMAX  600

// colours as 24-bit rgb
`define COLOUR_LOW      24'h00c040
`define COLOUR_MID      24'hf0c000
`define COLOUR_HIGH     24'he02020
`define SPRITE_COLOUR_A 24'hffffff
`define SPRITE_COLOUR_B 24'h3050ff

`endif

/* hw/vizPkg.sv */
package vizPkg;

	// screen coordinates
	typedef logic [9:0] pixelX;
	typedef logic [8:0] pixelY;

	// one channel of rgb
	typedef logic [7:0] colour;

	// band power, same width as the filter output
	typedef logic [10:0] bandLevel;

	// band number, 0 to 5 valid
	typedef logic [2:0] bandIndex;

	// which layer owns the pixel
	typedef enum logic [1:0] {
		LayerNone,
		LayerBar,
		LayerSprite
	} layerSel;

endpackage

/* hw/barRenderer.sv */
`include "viz_settings.svh"

module barRenderer (
	input  logic                   clk,
	input  logic                   rstN,
	input  vizPkg::pixelX          pixX,
	input  vizPkg::pixelY          pixY,
	input  logic                   levelStrobe,
	input  vizPkg::bandIndex       bandSel,
	input  vizPkg::bandLevel       levelIn,
	input  logic [`NUM_BANDS-1:0]  bandEnable,
	output logic                   barHit,
	output vizPkg::colour          barR,
	output vizPkg::colour          barG,
	output vizPkg::colour          barB
);

	vizPkg::bandLevel levels [`NUM_BANDS];

	logic             colHit;
	vizPkg::bandIndex colIdx;
	logic             rowHit;
	vizPkg::bandLevel rowThresh;
	logic [23:0]      rowRgb;
	logic             blockLit;

	// latest level per band, out-of-range band numbers dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int b = 0; b < `NUM_BANDS; b++) begin
				levels[b] <= '0;
			end
		end else if (levelStrobe && (bandSel < vizPkg::bandIndex'(`NUM_BANDS))) begin
			levels[bandSel] <= levelIn;
		end
	end

	// which band column holds the pixel
	always_comb begin
		colHit = 1'b0;
		colIdx = '0;
		for (int b = 0; b < `NUM_BANDS; b++) begin
			if (pixX >= vizPkg::pixelX'(`BAR_X0 + b * `BAR_PITCH_X) &&
					pixX < vizPkg::pixelX'(`BAR_X0 + b * `BAR_PITCH_X + `BLOCK_W)) begin
				colHit = 1'b1;
				colIdx = vizPkg::bandIndex'(b);
			end
		end
	end

	// which block row, its threshold and colour
	// row 0 is the top one and needs the most power
	always_comb begin
		rowHit    = 1'b0;
		rowThresh = '0;
		rowRgb    = '0;
		for (int r = 0; r < `NUM_BLOCKS; r++) begin
			if (pixY >= vizPkg::pixelY'(`BAR_Y0 + r * `BAR_PITCH_Y) &&
					pixY < vizPkg::pixelY'(`BAR_Y0 + r * `BAR_PITCH_Y + `BLOCK_H)) begin
				rowHit    = 1'b1;
				rowThresh = vizPkg::bandLevel'(`BAR_STEP * (`NUM_BLOCKS - 1 - r));
				if (r >= 4) begin
					rowRgb = `COLOUR_LOW;
				end else if (r >= 2) begin
					rowRgb = `COLOUR_MID;
				end else begin
					rowRgb = `COLOUR_HIGH;
				end
			end
		end
	end

	// levels read here are the ones before this edge's strobe
	assign blockLit = colHit && rowHit && bandEnable[colIdx] &&
		(levels[colIdx] > rowThresh);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			barHit <= 1'b0;
		end else begin
			barHit <= blockLit;
		end
	end

	// colour only matters when barHit is set
	always_ff @(posedge clk) begin
		{barR, barG, barB} <= blockLit ? rowRgb : 24'h000000;
	end

endmodule

/* hw/spriteRenderer.sv */
`include "viz_settings.svh"

module spriteRenderer (
	input  logic          clk,
	input  logic          rstN,
	input  vizPkg::pixelX pixX,
	input  vizPkg::pixelY pixY,
	input  logic          beat,
	input  logic          spriteEnable,
	output logic          spriteHit,
	output vizPkg::colour spriteR,
	output vizPkg::colour spriteG,
	output vizPkg::colour spriteB
);

	vizPkg::pixelX spriteX;
	logic [10:0]   steppedX;
	vizPkg::pixelX localX;
	vizPkg::pixelY localY;
	logic          inSprite;
	logic [23:0]   patternRgb;

	// one extra bit so the step can't overflow before the range check
	assign steppedX = {1'b0, spriteX} + 11'(`SPRITE_STEP);

	// sideways step per beat, wrap past the right limit
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			spriteX <= vizPkg::pixelX'(`SPRITE_X0);
		end else if (beat) begin
			if (steppedX > 11'(`SPRITE_XMAX)) begin
				spriteX <= vizPkg::pixelX'(`SPRITE_XMIN);
			end else begin
				spriteX <= steppedX[9:0];
			end
		end
	end

	// offsets inside the square, only meaningful when pixel is past the corner
	assign localX = pixX - spriteX;
	assign localY = pixY - vizPkg::pixelY'(`SPRITE_Y0);

	assign inSprite = spriteEnable &&
		(pixX >= spriteX) && (localX < vizPkg::pixelX'(`SPRITE_SIZE)) &&
		(pixY >= vizPkg::pixelY'(`SPRITE_Y0)) && (localY < vizPkg::pixelY'(`SPRITE_SIZE));

	// 8x8 checkerboard
	assign patternRgb = (localX[3] ^ localY[3]) ? `SPRITE_COLOUR_B : `SPRITE_COLOUR_A;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			spriteHit <= 1'b0;
		end else begin
			spriteHit <= inSprite;
		end
	end

	always_ff @(posedge clk) begin
		{spriteR, spriteG, spriteB} <= inSprite ? patternRgb : 24'h000000;
	end

endmodule

/* hw/layerCombiner.sv */
module layerCombiner (
	input  logic          clk,
	input  logic          rstN,
	input  logic          barHit,
	input  vizPkg::colour barR,
	input  vizPkg::colour barG,
	input  vizPkg::colour barB,
	input  logic          spriteHit,
	input  vizPkg::colour spriteR,
	input  vizPkg::colour spriteG,
	input  vizPkg::colour spriteB,
	output vizPkg::colour red,
	output vizPkg::colour green,
	output vizPkg::colour blue
);

	vizPkg::layerSel layer;

	// sprite sits on top of the bars
	always_comb begin
		if (spriteHit) begin
			layer = vizPkg::LayerSprite;
		end else if (barHit) begin
			layer = vizPkg::LayerBar;
		end else begin
			layer = vizPkg::LayerNone;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{red, green, blue} <= 24'h000000;
		end else begin
			case (layer)
				vizPkg::LayerSprite: {red, green, blue} <= {spriteR, spriteG, spriteB};
				vizPkg::LayerBar:    {red, green, blue} <= {barR, barG, barB};
				// background
				default:             {red, green, blue} <= 24'h000000;
			endcase
		end
	end

endmodule

/* hw/screenManager.sv */
`include "viz_settings.svh"

module screenManager (
	input  logic                   clk,
	input  logic                   rstN,
	input  vizPkg::pixelX          pixX,
	input  vizPkg::pixelY          pixY,
	input  logic                   levelStrobe,
	input  vizPkg::bandIndex       bandSel,
	input  vizPkg::bandLevel       levelIn,
	input  logic [`NUM_BANDS-1:0]  bandEnable,
	input  logic                   beat,
	input  logic                   spriteEnable,
	output vizPkg::colour          red,
	output vizPkg::colour          green,
	output vizPkg::colour          blue
);

	// renderer stage, one cycle after the pixel
	logic          barHit;
	vizPkg::colour barR;
	vizPkg::colour barG;
	vizPkg::colour barB;
	logic          spriteHit;
	vizPkg::colour spriteR;
	vizPkg::colour spriteG;
	vizPkg::colour spriteB;

	barRenderer i_barRenderer (
		.clk         (clk),
		.rstN        (rstN),
		.pixX        (pixX),
		.pixY        (pixY),
		.levelStrobe (levelStrobe),
		.bandSel     (bandSel),
		.levelIn     (levelIn),
		.bandEnable  (bandEnable),
		.barHit      (barHit),
		.barR        (barR),
		.barG        (barG),
		.barB        (barB)
	);

	spriteRenderer i_spriteRenderer (
		.clk          (clk),
		.rstN         (rstN),
		.pixX         (pixX),
		.pixY         (pixY),
		.beat         (beat),
		.spriteEnable (spriteEnable),
		.spriteHit    (spriteHit),
		.spriteR      (spriteR),
		.spriteG      (spriteG),
		.spriteB      (spriteB)
	);

	// second stage, rgb out two cycles after the pixel
	layerCombiner i_layerCombiner (
		.clk       (clk),
		.rstN      (rstN),
		.barHit    (barHit),
		.barR      (barR),
		.barG      (barG),
		.barB      (barB),
		.spriteHit (spriteHit),
		.spriteR   (spriteR),
		.spriteG   (spriteG),
		.spriteB   (spriteB),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

/* verification/clkGen.sv */
module clkGen (
	output logic clk,
	output logic rstN
);

	// 40 unit period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset released on a falling edge after 4 cycles
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

/* verification/screenManager_asserts.sv */
`include "viz_settings.svh"

module screenManager_asserts (
	input logic             clk,
	input logic             rstN,
	input logic             levelStrobe,
	input vizPkg::bandIndex bandSel,
	input logic             beat,
	input vizPkg::pixelX    spriteX,
	input vizPkg::colour    red,
	input vizPkg::colour    green,
	input vizPkg::colour    blue
);

	int failCount = 0;

	// rgb held black while in reset
	resetBlack: assert property (@(posedge clk) !rstN |-> (red == 0 && green == 0 && blue == 0))
		else begin
			failCount++;
			$error("rgb output not black during reset");
		end

	// one step right, or back to the left limit
	beatMove: assert property (@(posedge clk) disable iff (!rstN)
		beat |=> (spriteX == $past(spriteX) + `SPRITE_STEP && spriteX <= `SPRITE_XMAX) ||
			(spriteX == `SPRITE_XMIN && $past(spriteX) + `SPRITE_STEP > `SPRITE_XMAX))
		else begin
			failCount++;
			$error("sprite position after beat is neither a step nor a wrap");
		end

	bandRange: assert property (@(posedge clk) disable iff (!rstN)
		levelStrobe |-> bandSel <= 3'd5)
		else begin
			failCount++;
			$error("band index above 5 at level strobe");
		end

endmodule

/* verification/vizChecker.sv */
`include "viz_settings.svh"

module vizChecker (
	input  logic                  clk,
	input  logic                  rstN,
	input  vizPkg::pixelX         pixX,
	input  vizPkg::pixelY         pixY,
	input  logic                  levelStrobe,
	input  vizPkg::bandIndex      bandSel,
	input  vizPkg::bandLevel      levelIn,
	input  logic [`NUM_BANDS-1:0] bandEnable,
	input  logic                  beat,
	input  logic                  spriteEnable,
	input  vizPkg::colour         red,
	input  vizPkg::colour         green,
	input  vizPkg::colour         blue,
	input  logic [127:0]          testName,
	output int                    errorCount,
	output int                    checkCount
);

	// mirrored state, as seen from the inputs
	int           levels [`NUM_BANDS];
	int           spriteX;
	logic [23:0]  expNew;
	logic [23:0]  expOld;
	logic         validNew;
	logic         validOld;
	logic [127:0] nameNew;
	logic [127:0] nameOld;

	function automatic logic [23:0] refColour(input int x, input int y,
			input logic [`NUM_BANDS-1:0] en, input logic sprOn);
		int lx;
		int ly;
		int bx;
		int by;
		logic [23:0] rgb;
		lx = x - spriteX;
		ly = y - `SPRITE_Y0;
		// sprite on top, 8 pixel checker cells
		if (sprOn && lx >= 0 && lx < `SPRITE_SIZE && ly >= 0 && ly < `SPRITE_SIZE) begin
			return (((lx / 8) + (ly / 8)) % 2 == 0) ? `SPRITE_COLOUR_A : `SPRITE_COLOUR_B;
		end
		rgb = 24'h000000;
		for (int b = 0; b < `NUM_BANDS; b++) begin
			for (int r = 0; r < `NUM_BLOCKS; r++) begin
				bx = x - (`BAR_X0 + b * `BAR_PITCH_X);
				by = y - (`BAR_Y0 + r * `BAR_PITCH_Y);
				if (bx >= 0 && bx < `BLOCK_W && by >= 0 && by < `BLOCK_H && en[b] &&
						levels[b] > `BAR_STEP * (5 - r)) begin
					rgb = (r >= 4) ? `COLOUR_LOW : (r >= 2) ? `COLOUR_MID : `COLOUR_HIGH;
				end
			end
		end
		return rgb;
	endfunction

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	// expected colour from the state before this edge, then update the mirror
	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int b = 0; b < `NUM_BANDS; b++) begin
				levels[b] = 0;
			end
			spriteX  = `SPRITE_X0;
			validNew = 1'b0;
			validOld = 1'b0;
		end else begin
			expOld   = expNew;
			validOld = validNew;
			nameOld  = nameNew;
			expNew   = refColour(pixX, pixY, bandEnable, spriteEnable);
			nameNew  = testName;
			validNew = 1'b1;
			if (levelStrobe && bandSel < `NUM_BANDS) begin
				levels[bandSel] = levelIn;
			end
			if (beat) begin
				spriteX = (spriteX + `SPRITE_STEP > `SPRITE_XMAX) ? `SPRITE_XMIN :
					spriteX + `SPRITE_STEP;
			end
		end
	end

	// output after edge k belongs to the pixel of edge k-1
	always @(negedge clk) begin
		if (rstN && validOld) begin
			checkCount++;
			if ({red, green, blue} !== expOld) begin
				errorCount++;
				$display("FAIL %0s expected %06h actual %06h", nameOld, expOld,
					{red, green, blue});
			end
		end
	end

endmodule

/* verification/screenManagerTb.sv */
`include "viz_settings.svh"

module screenManagerTb;

	localparam int GridStep    = 9;
	localparam int GridCycles  = ((640 + GridStep - 1) / GridStep) *
		((480 + GridStep - 1) / GridStep);
	localparam int StripCycles = (640 / 8) * (`SPRITE_SIZE / 4);
	localparam int NumBeats    = 30;
	localparam int RandCycles  = 4000;
	localparam int TotalCycles = 5 * GridCycles + (NumBeats + 2) * (StripCycles + 1) +
		RandCycles + 100;

	logic                  clk;
	logic                  rstN;
	vizPkg::pixelX         pixX;
	vizPkg::pixelY         pixY;
	logic                  levelStrobe;
	vizPkg::bandIndex      bandSel;
	vizPkg::bandLevel      levelIn;
	logic [`NUM_BANDS-1:0] bandEnable;
	logic                  beat;
	logic                  spriteEnable;
	vizPkg::colour         red;
	vizPkg::colour         green;
	vizPkg::colour         blue;
	logic [127:0]          testName;
	int                    errorCount;
	int                    checkCount;
	logic [31:0]           lfsrState;

	clkGen i_clkGen (.clk(clk), .rstN(rstN));

	screenManager i_screenManager (.clk(clk), .rstN(rstN), .pixX(pixX), .pixY(pixY),
		.levelStrobe(levelStrobe), .bandSel(bandSel), .levelIn(levelIn),
		.bandEnable(bandEnable), .beat(beat), .spriteEnable(spriteEnable),
		.red(red), .green(green), .blue(blue));

	vizChecker i_vizChecker (.clk(clk), .rstN(rstN), .pixX(pixX), .pixY(pixY),
		.levelStrobe(levelStrobe), .bandSel(bandSel), .levelIn(levelIn),
		.bandEnable(bandEnable), .beat(beat), .spriteEnable(spriteEnable),
		.red(red), .green(green), .blue(blue), .testName(testName),
		.errorCount(errorCount), .checkCount(checkCount));

	bind screenManager screenManager_asserts i_asserts (.clk(clk), .rstN(rstN),
		.levelStrobe(levelStrobe), .bandSel(bandSel), .beat(beat),
		.spriteX(i_spriteRenderer.spriteX), .red(red), .green(green), .blue(blue));

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic drivePixel(input int x, input int y);
		@(negedge clk);
		levelStrobe = 1'b0;
		beat        = 1'b0;
		pixX        = vizPkg::pixelX'(x);
		pixY        = vizPkg::pixelY'(y);
	endtask

	task automatic setLevel(input int band, input int level);
		@(negedge clk);
		beat        = 1'b0;
		levelStrobe = 1'b1;
		bandSel     = vizPkg::bandIndex'(band);
		levelIn     = vizPkg::bandLevel'(level);
	endtask

	task automatic pulseBeat();
		@(negedge clk);
		levelStrobe = 1'b0;
		beat        = 1'b1;
	endtask

	task automatic scanGrid();
		for (int y = 0; y < 480; y += GridStep) begin
			for (int x = 0; x < 640; x += GridStep) begin
				drivePixel(x, y);
			end
		end
	endtask

	// rows crossed by the sprite only
	task automatic scanStrip();
		for (int y = `SPRITE_Y0; y < `SPRITE_Y0 + `SPRITE_SIZE; y += 4) begin
			for (int x = 0; x < 640; x += 8) begin
				drivePixel(x, y);
			end
		end
	endtask

	task automatic randomTraffic(input int n);
		logic [3:0] kind;
		for (int i = 0; i < n; i++) begin
			kind = 4'(randBits(4));
			@(negedge clk);
			pixX        = vizPkg::pixelX'(randBits(10));
			pixY        = vizPkg::pixelY'(randBits(9));
			levelStrobe = (kind < 4'd3);
			bandSel     = vizPkg::bandIndex'(randBits(8) % 6);
			levelIn     = vizPkg::bandLevel'(randBits(11));
			beat        = (kind == 4'd15);
			if (kind == 4'd7) begin
				bandEnable = `NUM_BANDS'(randBits(6));
			end
			if (kind == 4'd8) begin
				spriteEnable = 1'(randBits(1));
			end
		end
	endtask

	initial begin
		pixX         = '0;
		pixY         = '0;
		levelStrobe  = 1'b0;
		bandSel      = '0;
		levelIn      = '0;
		bandEnable   = '1;
		beat         = 1'b0;
		spriteEnable = 1'b1;
		lfsrState    = 32'h64df;
		testName     = "reset";
		@(posedge rstN);
		scanGrid();
		testName = "levels";
		for (int b = 0; b < `NUM_BANDS; b++) begin
			setLevel(b, b * `BAR_STEP + 150);
		end
		scanGrid();
		testName   = "enable";
		bandEnable = 6'b010110;
		scanGrid();
		testName   = "beat";
		bandEnable = '1;
		repeat (NumBeats) begin
			pulseBeat();
			scanStrip();
		end
		// sprite now sits over band 1, row 1
		testName = "overlap";
		for (int b = 0; b < `NUM_BANDS; b++) begin
			setLevel(b, 2047);
		end
		scanGrid();
		scanStrip();
		spriteEnable = 1'b0;
		scanStrip();
		spriteEnable = 1'b1;
		testName = "random";
		randomTraffic(RandCycles);
		repeat (3) drivePixel(0, 0);
		// let the compare at this falling edge settle first
		@(posedge clk);
		$display("checks %0d errors %0d assertion failures %0d", checkCount, errorCount,
			i_screenManager.i_asserts.failCount);
		if (errorCount == 0 && i_screenManager.i_asserts.failCount == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		#(TotalCycles * 40 + 10000);
		$display("watchdog expired before the stimulus finished");
		$display("sim failed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hw
hw/vizPkg.sv
hw/barRenderer.sv
hw/spriteRenderer.sv
hw/layerCombiner.sv
hw/screenManager.sv
verification/clkGen.sv
verification/screenManager_asserts.sv
verification/vizChecker.sv
verification/screenManagerTb.sv

/* Bender.yml */
package:
  name: screen_manager

sources:
  - include_dirs:
      - hw
    files:
      - hw/vizPkg.sv
      - hw/barRenderer.sv
      - hw/spriteRenderer.sv
      - hw/layerCombiner.sv
      - hw/screenManager.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/clkGen.sv
      - verification/screenManager_asserts.sv
      - verification/vizChecker.sv
      - verification/screenManagerTb.sv
